// File: all.f
hw/divPkg.sv
hw/divOperandPrep.sv
hw/divQueue.sv
hw/divCore.sv
hw/divUnit.sv
sim/divUnitTb.sv

// File: Makefile
SIM      := verilator
TOP      := divUnitTb
FILELIST := all.f
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
BUILD    := obj_dir

SOURCES  := $(shell cat $(FILELIST))

.PHONY: compile run clean

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: sim/divUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module divUnitTb;
    import divPkg::*;

    localparam int NUM_OPS     = 200;
    localparam int MAX_LATENCY = 60;

    logic             clk;
    logic             rst;
    logic             inValid;
    divOp             inOp;
    logic [XLEN-1:0]  inSrcA;
    logic [XLEN-1:0]  inSrcB;
    logic [SQN_W-1:0] inSqN;
    logic [TAG_W-1:0] inTag;
    logic             branchTaken;
    logic [SQN_W-1:0] branchSqN;
    logic             resultValid;
    logic [TAG_W-1:0] resultTag;
    logic [SQN_W-1:0] resultSqN;
    logic [XLEN-1:0]  resultData;
    logic             queueFull;

    logic [TAG_W-1:0] modelTag  [$];  // oldest outstanding micro-op at index 0
    logic [SQN_W-1:0] modelSqN  [$];
    logic [XLEN-1:0]  modelData [$];
    logic             expValid;
    logic [TAG_W-1:0] expTag;
    logic [SQN_W-1:0] expSqN;
    logic [XLEN-1:0]  expData;
    int               expCount;
    logic [SQN_W-1:0] nextSqN;
    logic [TAG_W-1:0] nextTag;

    divUnit u_divUnit (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inOp(inOp), .inSrcA(inSrcA), .inSrcB(inSrcB),
        .inSqN(inSqN), .inTag(inTag),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .resultValid(resultValid), .resultTag(resultTag),
        .resultSqN(resultSqN), .resultData(resultData),
        .queueFull(queueFull)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic flushedBy(input logic [SQN_W-1:0] sqN, input logic [SQN_W-1:0] brSqN);
        logic signed [SQN_W-1:0] age;
        age = sqN - brSqN;
        return age > 0;
    endfunction

    // RISC-V M rules, including divide by zero and the signed overflow case
    function automatic logic [XLEN-1:0] expectedResult(input divOp op, input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   overflow;
        sa = a;
        sb = b;
        overflow = (a == 32'h8000_0000) && (b == '1);
        if (op == DIV) begin
            if (b == '0) return '1;
            else if (overflow) return a;
            else return sa / sb;
        end else if (op == REM) begin
            if (b == '0) return a;
            else if (overflow) return '0;
            else return sa % sb;
        end else if (op == DIVU) begin
            if (b == '0) return '1;
            else return a / b;
        end else begin
            if (b == '0) return a;
            else return a % b;
        end
    endfunction

    // ------------------------------------------------------------
    // reference model, updated from the same inputs the DUT samples
    // ------------------------------------------------------------
    always @(posedge clk) begin : modelUpdate
        int idx;
        if (rst) begin
            modelTag.delete();
            modelSqN.delete();
            modelData.delete();
        end else begin
            if (resultValid && modelTag.size() > 0) begin  // a result leaves before a flush acts
                void'(modelTag.pop_front());
                void'(modelSqN.pop_front());
                void'(modelData.pop_front());
            end
            if (branchTaken) begin
                for (idx = modelSqN.size() - 1; idx >= 0; idx--) begin
                    if (flushedBy(modelSqN[idx], branchSqN)) begin
                        modelTag.delete(idx);
                        modelSqN.delete(idx);
                        modelData.delete(idx);
                    end
                end
            end
            if (inValid && !(branchTaken && flushedBy(inSqN, branchSqN))) begin
                modelTag.push_back(inTag);
                modelSqN.push_back(inSqN);
                modelData.push_back(expectedResult(inOp, inSrcA, inSrcB));
            end
        end
        expValid <= modelTag.size() > 0;
        expCount <= modelTag.size();
        if (modelTag.size() > 0) begin
            expTag  <= modelTag[0];
            expSqN  <= modelSqN[0];
            expData <= modelData[0];
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    resultExpected: assert property (@(posedge clk) disable iff (rst) resultValid |-> expValid)
        else abortRun($sformatf("ERR %0t: result tag %0d sqn %0d with nothing outstanding",
                                $time, resultTag, resultSqN));

    resultMatches: assert property (@(posedge clk) disable iff (rst)
        (resultValid && expValid) |->
            (resultTag == expTag && resultSqN == expSqN && resultData == expData))
        else abortRun($sformatf("ERR %0t: got tag %0d sqn %0d data %h, expected %0d %0d %h",
                                $time, resultTag, resultSqN, resultData, expTag, expSqN, expData));

    fullLowAfterReset: assert property (@(posedge clk) $fell(rst) |-> !queueFull)
        else abortRun($sformatf("ERR %0t: queueFull is set right after reset", $time));

    task automatic issueOp(input divOp op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        inValid <= 1'b1;
        inOp    <= op;
        inSrcA  <= a;
        inSrcB  <= b;
        inSqN   <= nextSqN;
        inTag   <= nextTag;
        nextSqN = nextSqN + 1'b1;
        nextTag = nextTag + 1'b1;
    endtask

    task automatic issueRandomOp();
        divOp            op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              pick;
        op   = divOp'($urandom_range(0, 3));
        a    = $urandom();
        b    = $urandom();
        pick = $urandom_range(0, 9);
        case (pick)
            0: b = '0;
            1: begin
                a = 32'h8000_0000;
                b = '1;
            end
            2: a = '1;
            3: b = '1;
            4: b = $urandom_range(1, 100);  // small divisors give wide quotients
            default: ;
        endcase
        issueOp(op, a, b);
    endtask

    task automatic sendBranch();
        branchTaken <= 1'b1;
        branchSqN   <= nextSqN - 1'b1 - SQN_W'($urandom_range(0, 5));
    endtask

    task automatic waitDrain();
        int limit;
        int cycles;
        limit  = 34 * expCount + 36;
        cycles = 0;
        while (expCount != 0) begin
            if (cycles >= limit) abortRun("outstanding micro-ops did not complete in time");
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        int cycles;
        int issued;
        logic room;
        void'($urandom(32'hae9f));
        clk         = 1'b0;
        rst         = 1'b1;
        inValid     = 1'b0;
        inOp        = DIV;
        inSrcA      = '0;
        inSrcB      = '0;
        inSqN       = '0;
        inTag       = '0;
        branchTaken = 1'b0;
        branchSqN   = '0;
        nextSqN     = '0;
        nextTag     = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // ------------------------------------------------------------
        // single micro-op into an empty unit
        // ------------------------------------------------------------
        @(posedge clk);
        issueOp(DIVU, 32'd1000, 32'd7);
        @(negedge clk);
        cycles = 0;
        @(posedge clk);
        inValid <= 1'b0;
        while (!resultValid) begin
            if (cycles >= MAX_LATENCY) abortRun("no result came back for the single micro-op");
            @(negedge clk);
            cycles++;
        end
        assert (cycles == 36)
            else abortRun($sformatf("ERR %0t: latency %0d cycles, expected 36", $time, cycles));
        waitDrain();

        // ------------------------------------------------------------
        // four back to back behind a busy core fill the queue
        // ------------------------------------------------------------
        @(posedge clk);
        issueOp(REM, 32'hffff_fff9, 32'd2);
        @(posedge clk);
        inValid <= 1'b0;
        repeat (3) @(posedge clk);  // core has popped it by now
        issueOp(DIV, 32'h8000_0000, '1);
        @(posedge clk);
        issueOp(REM, 32'd12345, '0);
        @(posedge clk);
        issueOp(DIVU, '1, 32'd3);
        @(posedge clk);
        issueOp(REMU, '1, '0);
        @(posedge clk);
        inValid <= 1'b0;
        @(negedge clk);
        cycles = 0;
        while (!queueFull) begin
            if (cycles >= 8) abortRun("queueFull did not rise after four back-to-back micro-ops");
            @(negedge clk);
            cycles++;
        end

        // ------------------------------------------------------------
        // random traffic with flushes
        // ------------------------------------------------------------
        issued = 0;
        cycles = 0;
        while (issued < NUM_OPS) begin
            if (cycles >= NUM_OPS * 80) abortRun("random stimulus stalled waiting for queue space");
            @(negedge clk);
            room = !queueFull && !inValid;  // an unregistered strobe is not yet in queueFull
            @(posedge clk);
            inValid     <= 1'b0;
            branchTaken <= 1'b0;
            if (room && $urandom_range(0, 3) != 0) begin
                issueRandomOp();
                issued++;
            end
            if ($urandom_range(0, 39) == 0) sendBranch();
            cycles++;
        end
        @(posedge clk);
        inValid     <= 1'b0;
        branchTaken <= 1'b0;
        @(negedge clk);
        waitDrain();
        repeat (40) @(posedge clk);  // any late result from a flushed micro-op would trip a check
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/divUnit.sv
`timescale 1ns/1ps
`default_nettype none

module divUnit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inValid,
    input  divPkg::divOp              inOp,
    input  logic [divPkg::XLEN-1:0]   inSrcA,
    input  logic [divPkg::XLEN-1:0]   inSrcB,
    input  logic [divPkg::SQN_W-1:0]  inSqN,
    input  logic [divPkg::TAG_W-1:0]  inTag,
    input  logic                      branchTaken,
    input  logic [divPkg::SQN_W-1:0]  branchSqN,
    output logic                      resultValid,
    output logic [divPkg::TAG_W-1:0]  resultTag,
    output logic [divPkg::SQN_W-1:0]  resultSqN,
    output logic [divPkg::XLEN-1:0]   resultData,
    output logic                      queueFull
);
    import divPkg::*;

    // ------------------------------------------------------------
    // operand stage to queue
    // ------------------------------------------------------------
    logic             prepValid;
    logic [XLEN-1:0]  prepMagA;
    logic [XLEN-1:0]  prepMagB;
    logic             prepNegate;
    logic             prepIsRem;
    logic [SQN_W-1:0] prepSqN;
    logic [TAG_W-1:0] prepTag;

    // ------------------------------------------------------------
    // queue head to divider
    // ------------------------------------------------------------
    logic             headValid;
    logic [XLEN-1:0]  headMagA;
    logic [XLEN-1:0]  headMagB;
    logic             headNegate;
    logic             headIsRem;
    logic [SQN_W-1:0] headSqN;
    logic [TAG_W-1:0] headTag;
    logic             headPop;

    divOperandPrep u_divOperandPrep (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inOp(inOp), .inSrcA(inSrcA), .inSrcB(inSrcB),
        .inSqN(inSqN), .inTag(inTag),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .prepValid(prepValid), .prepMagA(prepMagA), .prepMagB(prepMagB),
        .prepNegate(prepNegate), .prepIsRem(prepIsRem),
        .prepSqN(prepSqN), .prepTag(prepTag)
    );

    divQueue u_divQueue (
        .clk(clk), .rst(rst),
        .prepValid(prepValid), .prepMagA(prepMagA), .prepMagB(prepMagB),
        .prepNegate(prepNegate), .prepIsRem(prepIsRem),
        .prepSqN(prepSqN), .prepTag(prepTag),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .headPop(headPop),
        .headValid(headValid), .headMagA(headMagA), .headMagB(headMagB),
        .headNegate(headNegate), .headIsRem(headIsRem),
        .headSqN(headSqN), .headTag(headTag),
        .queueFull(queueFull)
    );

    divCore u_divCore (
        .clk(clk), .rst(rst),
        .headValid(headValid), .headMagA(headMagA), .headMagB(headMagB),
        .headNegate(headNegate), .headIsRem(headIsRem),
        .headSqN(headSqN), .headTag(headTag),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .headPop(headPop),
        .resultValid(resultValid), .resultTag(resultTag),
        .resultSqN(resultSqN), .resultData(resultData)
    );

endmodule

`default_nettype wire

// File: hw/divCore.sv
`timescale 1ns/1ps
`default_nettype none

module divCore (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      headValid,
    input  logic [divPkg::XLEN-1:0]   headMagA,
    input  logic [divPkg::XLEN-1:0]   headMagB,
    input  logic                      headNegate,
    input  logic                      headIsRem,
    input  logic [divPkg::SQN_W-1:0]  headSqN,
    input  logic [divPkg::TAG_W-1:0]  headTag,
    input  logic                      branchTaken,
    input  logic [divPkg::SQN_W-1:0]  branchSqN,
    output logic                      headPop,
    output logic                      resultValid,
    output logic [divPkg::TAG_W-1:0]  resultTag,
    output logic [divPkg::SQN_W-1:0]  resultSqN,
    output logic [divPkg::XLEN-1:0]   resultData
);
    import divPkg::*;

    divCoreState               state;
    logic [$clog2(XLEN)-1:0]   stepCnt;
    logic [2*XLEN:0]           partRem;  // partial remainder on top, quotient bits below
    logic [XLEN-1:0]           divisor;
    logic                      negate;
    logic                      isRem;
    logic [SQN_W-1:0]          heldSqN;
    logic [TAG_W-1:0]          heldTag;

    logic                      startOk;
    logic                      flushHit;
    logic [XLEN:0]             stepAddend;
    logic [XLEN-1:0]           quotRaw;
    logic [XLEN-1:0]           quotFixed;
    logic [XLEN-1:0]           remFixed;
    logic [XLEN-1:0]           resultSel;

    assign headPop  = (state == IDLE) && headValid;
    assign startOk  = headPop && !(branchTaken && isYounger(headSqN, branchSqN));
    assign flushHit = branchTaken && isYounger(heldSqN, branchSqN);

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    // negative partial remainder adds the divisor back, otherwise subtract
    assign stepAddend = partRem[2*XLEN] ? {1'b0, divisor} : -{1'b0, divisor};

    // quotient digits are +1/-1 coded and get converted to plain binary
    assign quotRaw   = partRem[XLEN-1:0];
    assign quotFixed = quotRaw - ~quotRaw - {{(XLEN-1){1'b0}}, partRem[2*XLEN]};
    assign remFixed  = partRem[2*XLEN] ? (partRem[2*XLEN-1:XLEN] + divisor)
                                       : partRem[2*XLEN-1:XLEN];
    assign resultSel = isRem ? remFixed : quotFixed;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            stepCnt     <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (startOk) begin
                        state   <= ITERATE;
                        stepCnt <= '1;  // one step per quotient bit
                    end
                end
                ITERATE: begin
                    if (flushHit) begin
                        state <= IDLE;
                    end else if (stepCnt == '0) begin
                        state <= FINISH;
                    end else begin
                        stepCnt <= stepCnt - 1'b1;
                    end
                end
                FINISH: begin
                    state       <= IDLE;
                    resultValid <= !flushHit;  // a late flush still suppresses the result
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (startOk) begin
            partRem <= {{(XLEN+1){1'b0}}, headMagA};
            divisor <= headMagB;
            negate  <= headNegate;
            isRem   <= headIsRem;
            heldSqN <= headSqN;
            heldTag <= headTag;
        end else if (state == ITERATE) begin
            partRem <= (partRem << 1) + {stepAddend, {(XLEN-1){1'b0}}, ~partRem[2*XLEN]};
        end
        if (state == FINISH) begin
            resultData <= negate ? -resultSel : resultSel;
            resultSqN  <= heldSqN;
            resultTag  <= heldTag;
        end
    end

    // ------------------------------------------------------------
    // results only ever follow a FINISH cycle
    // ------------------------------------------------------------
    resultAfterFinish: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> ($past(state) == FINISH));

endmodule

`default_nettype wire

// File: hw/divQueue.sv
`timescale 1ns/1ps
`default_nettype none

module divQueue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      prepValid,
    input  logic [divPkg::XLEN-1:0]   prepMagA,
    input  logic [divPkg::XLEN-1:0]   prepMagB,
    input  logic                      prepNegate,
    input  logic                      prepIsRem,
    input  logic [divPkg::SQN_W-1:0]  prepSqN,
    input  logic [divPkg::TAG_W-1:0]  prepTag,
    input  logic                      branchTaken,
    input  logic [divPkg::SQN_W-1:0]  branchSqN,
    input  logic                      headPop,
    output logic                      headValid,
    output logic [divPkg::XLEN-1:0]   headMagA,
    output logic [divPkg::XLEN-1:0]   headMagB,
    output logic                      headNegate,
    output logic                      headIsRem,
    output logic [divPkg::SQN_W-1:0]  headSqN,
    output logic [divPkg::TAG_W-1:0]  headTag,
    output logic                      queueFull
);
    import divPkg::*;

    logic [XLEN-1:0]  entryMagA   [QUEUE_DEPTH];
    logic [XLEN-1:0]  entryMagB   [QUEUE_DEPTH];
    logic             entryNegate [QUEUE_DEPTH];
    logic             entryIsRem  [QUEUE_DEPTH];
    logic [SQN_W-1:0] entrySqN    [QUEUE_DEPTH];
    logic [TAG_W-1:0] entryTag    [QUEUE_DEPTH];

    logic [QUEUE_DEPTH-1:0]           entryValid;
    logic [$clog2(QUEUE_DEPTH)-1:0]   rdPtr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   wrPtr;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] count;  // includes flushed slots not yet retired
    logic push;
    logic skipHead;
    logic retire;

    assign push     = prepValid && !(branchTaken && isYounger(prepSqN, branchSqN));
    assign headValid = (count != '0) && entryValid[rdPtr];
    assign skipHead  = (count != '0) && !entryValid[rdPtr];  // a dead slot is dropped quietly
    assign retire    = headPop || skipHead;

    // the operand stage holds one more micro-op, so count it as already here
    assign queueFull = (int'(count) + int'(prepValid)) >= QUEUE_DEPTH;

    assign headMagA   = entryMagA[rdPtr];
    assign headMagB   = entryMagB[rdPtr];
    assign headNegate = entryNegate[rdPtr];
    assign headIsRem  = entryIsRem[rdPtr];
    assign headSqN    = entrySqN[rdPtr];
    assign headTag    = entryTag[rdPtr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entryValid <= '0;
            rdPtr      <= '0;
            wrPtr      <= '0;
            count      <= '0;
        end else begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (branchTaken && isYounger(entrySqN[i], branchSqN)) begin
                    entryValid[i] <= 1'b0;
                end
            end
            if (retire) begin
                entryValid[rdPtr] <= 1'b0;
                rdPtr             <= rdPtr + 1'b1;
            end
            if (push) begin
                entryValid[wrPtr] <= 1'b1;  // wins over the flush loop above
                wrPtr             <= wrPtr + 1'b1;
            end
            case ({push, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entryMagA[wrPtr]   <= prepMagA;
            entryMagB[wrPtr]   <= prepMagB;
            entryNegate[wrPtr] <= prepNegate;
            entryIsRem[wrPtr]  <= prepIsRem;
            entrySqN[wrPtr]    <= prepSqN;
            entryTag[wrPtr]    <= prepTag;
        end
    end

    // ------------------------------------------------------------
    // the issuer honours queueFull and the core only takes live heads
    // ------------------------------------------------------------
    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        prepValid |-> (int'(count) < QUEUE_DEPTH));

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        headPop |-> headValid);

endmodule

`default_nettype wire

// File: hw/divOperandPrep.sv
`timescale 1ns/1ps
`default_nettype none

module divOperandPrep (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inValid,
    input  divPkg::divOp              inOp,
    input  logic [divPkg::XLEN-1:0]   inSrcA,
    input  logic [divPkg::XLEN-1:0]   inSrcB,
    input  logic [divPkg::SQN_W-1:0]  inSqN,
    input  logic [divPkg::TAG_W-1:0]  inTag,
    input  logic                      branchTaken,
    input  logic [divPkg::SQN_W-1:0]  branchSqN,
    output logic                      prepValid,
    output logic [divPkg::XLEN-1:0]   prepMagA,
    output logic [divPkg::XLEN-1:0]   prepMagB,
    output logic                      prepNegate,
    output logic                      prepIsRem,
    output logic [divPkg::SQN_W-1:0]  prepSqN,
    output logic [divPkg::TAG_W-1:0]  prepTag
);
    import divPkg::*;

    logic            accept;
    logic            isSigned;
    logic            negate;
    logic [XLEN-1:0] magA;
    logic [XLEN-1:0] magB;

    assign accept   = inValid && !(branchTaken && isYounger(inSqN, branchSqN));
    assign isSigned = (inOp == DIV) || (inOp == REM);

    // unsigned ops go through untouched because the core only ever sees magnitudes
    assign magA = (isSigned && inSrcA[XLEN-1]) ? -inSrcA : inSrcA;
    assign magB = (isSigned && inSrcB[XLEN-1]) ? -inSrcB : inSrcB;

    always_comb begin
        case (inOp)
            DIV:     negate = (inSrcA[XLEN-1] ^ inSrcB[XLEN-1]) && (inSrcB != '0);
            REM:     negate = inSrcA[XLEN-1];  // remainder takes the dividend sign
            default: negate = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prepValid <= 1'b0;
        end else begin
            prepValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prepMagA   <= magA;
            prepMagB   <= magB;
            prepNegate <= negate;
            prepIsRem  <= (inOp == REM) || (inOp == REMU);
            prepSqN    <= inSqN;
            prepTag    <= inTag;
        end
    end

    // ------------------------------------------------------------
    // a micro-op killed by a same-cycle branch never reaches the queue
    // ------------------------------------------------------------
    staleNotForwarded: assert property (@(posedge clk) disable iff (rst)
        (inValid && branchTaken && isYounger(inSqN, branchSqN)) |=> !prepValid);

endmodule

`default_nettype wire

// File: hw/divPkg.sv
`default_nettype none

package divPkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int SQN_W       = 7;   // sequence numbers wrap, so age is a signed difference
    localparam int TAG_W       = 6;
    localparam int QUEUE_DEPTH = 4;

    // ------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        DIV  = 2'd0,
        DIVU = 2'd1,
        REM  = 2'd2,
        REMU = 2'd3
    } divOp;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ITERATE = 2'd1,
        FINISH  = 2'd2
    } divCoreState;

    // true when sqN was issued after refSqN, which is what a taken branch kills
    function automatic logic isYounger(
        input logic [SQN_W-1:0] sqN,
        input logic [SQN_W-1:0] refSqN
    );
        logic [SQN_W-1:0] diff;
        diff = sqN - refSqN;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire
